// File: eth_tx_path.f
+incdir+hw
hw/eth_tx_pkg.sv
hw/eth_tx_stream_if.sv
hw/tx_stream_fifo.sv
hw/txc_parser.sv
hw/tx_frame_emitter.sv
hw/eth_tx_path.sv
verif/eth_tx_path_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the TX path testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ns -f eth_tx_path.f \
   --top-module eth_tx_path_tb -o eth_tx_path_sim \
   && ./obj_dir/eth_tx_path_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0

// File: verif/eth_tx_path_tb.sv
// ####################
// Directed testbench for the Ethernet TX output path
// Writes control and data frames, checks the MAC stream
// ####################
`timescale 1ns/1ns
`include "eth_tx_defines.svh"

module eth_tx_path_tb;

   localparam int CLK_PERIOD     = 8;
   localparam int DRIVE_DLY      = 1;
   // About twice the summed length of all tests
   localparam int TIMEOUT_CYCLES = 4000;
   localparam int MIN_BYTES      = `ETH_MIN_FRAME_BYTES;

   logic                       tx_clk;
   logic                       rst_n;
   logic                       ctrl_wr;
   logic [`ETH_TXC_DATA_W-1:0] ctrl_data;
   logic [`ETH_TXC_KEEP_W-1:0] ctrl_tag;
   logic                       ctrl_last;
   logic                       ctrl_afull;
   logic                       data_wr;
   logic [`ETH_TXD_DATA_W-1:0] data_data;
   logic [`ETH_TXD_KEEP_W-1:0] data_keep;
   logic                       data_last;
   logic                       data_afull;
   logic [`ETH_TXD_DATA_W-1:0] mac_tdata;
   logic [`ETH_TXD_KEEP_W-1:0] mac_tkeep;
   logic                       mac_tlast;
   logic                       mac_tuser;
   logic                       mac_tvalid;
   logic                       mac_tready;

   int          err_cnt      = 0;
   int          tests_run    = 0;
   int          tests_failed = 0;
   int          cycle_cnt    = 0;
   // 0 holds tready low, 1 holds it high, 2 draws it from the LFSR
   int          ready_mode   = 1;
   int          data_beats_written = 0;
   int          rx_mid_bad;
   logic [31:0] lfsr_state;
   logic [7:0]  rx_bytes[$];
   logic [7:0]  rx_last_keep;
   logic        rx_last_tuser;

   eth_tx_path u_dut (.*);

   initial begin
      tx_clk = 1'b0;
      forever #(CLK_PERIOD / 2) tx_clk = ~tx_clk;
   end

   initial begin
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge tx_clk);
         cycle_cnt++;
      end
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   initial begin
      lfsr_state = 32'h35d25e66;
      mac_tready = 1'b0;
      forever begin
         @(posedge tx_clk);
         #DRIVE_DLY;
         case (ready_mode)
            0: mac_tready = 1'b0;
            1: mac_tready = 1'b1;
            default: begin
               lfsr_state = lfsr_next(lfsr_state);
               mac_tready = lfsr_state[0];
            end
         endcase
      end
   end

   task automatic check_value(input string test_name, input string what,
                              input logic [63:0] expected, input logic [63:0] actual);
      if (expected !== actual) begin
         err_cnt++;
         $display("** Error %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
      end
   endtask

   task automatic write_ctrl_frame(input logic [3:0] flag, input logic no_pad,
                                   input logic early_last);
      int          n_words;
      logic [31:0] w;
      // Early tlast ends the frame on tag 3
      n_words = early_last ? 4 : 6;
      for (int t = 0; t < n_words; t++) begin
         case (t)
            0:       w = {flag, 28'h0};
            1:       w = {31'h0, no_pad};
            default: w = {8'(t), 24'h0};
         endcase
         @(posedge tx_clk);
         #DRIVE_DLY;
         while (ctrl_afull) begin
            ctrl_wr = 1'b0;
            @(posedge tx_clk);
            #DRIVE_DLY;
         end
         ctrl_wr   = 1'b1;
         ctrl_data = w;
         ctrl_tag  = 4'(t);
         ctrl_last = (t == n_words - 1);
      end
      @(posedge tx_clk);
      #DRIVE_DLY;
      ctrl_wr = 1'b0;
   endtask

   task automatic write_data_frame(input logic [7:0] base, input int n_bytes);
      int          beats;
      int          idx;
      logic [63:0] d;
      logic [7:0]  k;
      beats = (n_bytes + 7) / 8;
      for (int b = 0; b < beats; b++) begin
         d = '0;
         k = '0;
         for (int i = 0; i < 8; i++) begin
            idx = b * 8 + i;
            if (idx < n_bytes) begin
               d[i*8 +: 8] = 8'(base + idx);
               k[i]        = 1'b1;
            end
         end
         @(posedge tx_clk);
         #DRIVE_DLY;
         while (data_afull) begin
            data_wr = 1'b0;
            @(posedge tx_clk);
            #DRIVE_DLY;
         end
         data_wr   = 1'b1;
         data_data = d;
         data_keep = k;
         data_last = (b == beats - 1);
         data_beats_written++;
      end
      @(posedge tx_clk);
      #DRIVE_DLY;
      data_wr = 1'b0;
   endtask

   task automatic write_frame(input logic [3:0] flag, input logic no_pad,
                              input logic early_last, input logic [7:0] base, input int n_bytes);
      write_ctrl_frame(flag, no_pad, early_last);
      write_data_frame(base, n_bytes);
   endtask

   // Sampled at the falling edge, where data and tready are both settled
   task automatic collect_frame();
      bit done;
      done = 1'b0;
      rx_bytes.delete();
      rx_mid_bad = 0;
      while (!done) begin
         @(negedge tx_clk);
         if (mac_tvalid && mac_tready) begin
            for (int i = 0; i < 8; i++) begin
               if (mac_tkeep[i]) begin
                  rx_bytes.push_back(mac_tdata[i*8 +: 8]);
               end
            end
            if (mac_tlast) begin
               rx_last_keep  = mac_tkeep;
               rx_last_tuser = mac_tuser;
               done          = 1'b1;
            end else if (mac_tkeep != 8'hFF || mac_tuser) begin
               rx_mid_bad++;
            end
         end
      end
   endtask

   task automatic compare_frame(input string test_name, input logic [7:0] base,
                                input int n_bytes, input logic no_pad, input logic bad);
      int         exp_len;
      int         r;
      int         e0;
      logic [7:0] exp_byte;
      logic [7:0] exp_keep;
      exp_len  = (n_bytes < MIN_BYTES && !no_pad) ? MIN_BYTES : n_bytes;
      r        = exp_len % 8;
      exp_keep = (r == 0) ? 8'hFF : 8'((1 << r) - 1);
      check_value(test_name, "frame length", 64'(exp_len), 64'(rx_bytes.size()));
      e0 = err_cnt;
      // Stops at the first wrong byte
      for (int i = 0; i < exp_len && i < rx_bytes.size() && err_cnt == e0; i++) begin
         exp_byte = (i < n_bytes) ? 8'(base + i) : 8'h00;
         check_value(test_name, $sformatf("byte %0d", i), 64'(exp_byte), 64'(rx_bytes[i]));
      end
      check_value(test_name, "last keep", 64'(exp_keep), 64'(rx_last_keep));
      check_value(test_name, "last tuser", 64'(bad), 64'(rx_last_tuser));
      check_value(test_name, "beats before last with bad keep or tuser", 64'(0),
                  64'(rx_mid_bad));
   endtask

   task automatic send_and_check(input string test_name, input logic [3:0] flag,
                                 input logic no_pad, input logic early_last,
                                 input logic [7:0] base, input int n_bytes);
      fork
         write_frame(flag, no_pad, early_last, base, n_bytes);
         begin
            collect_frame();
            compare_frame(test_name, base, n_bytes, no_pad,
                          (flag != `ETH_TXC_FLAG) || early_last);
         end
      join
   endtask

   task automatic end_test(input string test_name, input int e0);
      tests_run++;
      if (err_cnt != e0) begin
         tests_failed++;
         $display("%s: failed with %0d errors", test_name, err_cnt - e0);
      end else begin
         $display("%s: ok", test_name);
      end
   endtask

   task automatic test_long_frame();
      int e0;
      e0 = err_cnt;
      send_and_check("long_frame", `ETH_TXC_FLAG, 1'b0, 1'b0, 8'h01, 253);
      end_test("long_frame", e0);
   endtask

   task automatic test_short_pad();
      int e0;
      e0 = err_cnt;
      send_and_check("short_pad", `ETH_TXC_FLAG, 1'b0, 1'b0, 8'h30, 20);
      end_test("short_pad", e0);
   endtask

   task automatic test_short_no_pad();
      int e0;
      e0 = err_cnt;
      send_and_check("short_no_pad", `ETH_TXC_FLAG, 1'b1, 1'b0, 8'h30, 20);
      end_test("short_no_pad", e0);
   endtask

   task automatic test_bad_ctrl();
      int e0;
      e0 = err_cnt;
      send_and_check("bad_ctrl", 4'h5, 1'b0, 1'b0, 8'h60, 20);
      send_and_check("bad_ctrl", `ETH_TXC_FLAG, 1'b0, 1'b1, 8'h70, 70);
      send_and_check("bad_ctrl", `ETH_TXC_FLAG, 1'b0, 1'b0, 8'h80, 70);
      end_test("bad_ctrl", e0);
   endtask

   task automatic test_back_pressure();
      int e0;
      e0 = err_cnt;
      ready_mode = 2;
      fork
         begin
            write_frame(`ETH_TXC_FLAG, 1'b0, 1'b0, 8'h20, 253);
            write_frame(`ETH_TXC_FLAG, 1'b0, 1'b0, 8'h50, 264);
            write_frame(`ETH_TXC_FLAG, 1'b0, 1'b0, 8'hA0, 267);
         end
         begin
            collect_frame();
            compare_frame("back_pressure", 8'h20, 253, 1'b0, 1'b0);
            collect_frame();
            compare_frame("back_pressure", 8'h50, 264, 1'b0, 1'b0);
            collect_frame();
            compare_frame("back_pressure", 8'hA0, 267, 1'b0, 1'b0);
         end
      join
      ready_mode = 1;
      end_test("back_pressure", e0);
   endtask

   task automatic test_almost_full();
      int e0;
      int waited;
      bit afull_seen;
      e0         = err_cnt;
      waited     = 0;
      afull_seen = 1'b0;
      ready_mode = 0;
      data_beats_written = 0;
      repeat (2) @(posedge tx_clk);
      fork
         write_frame(`ETH_TXC_FLAG, 1'b0, 1'b0, 8'h90, 128);
         begin
            while (!afull_seen && waited < 64) begin
               @(negedge tx_clk);
               waited++;
               afull_seen = data_afull;
            end
            check_value("almost_full", "data_afull rose", 64'(1), 64'(afull_seen));
            check_value("almost_full", "afull level reached", 64'(1),
                        64'(data_beats_written >= `ETH_FIFO_AFULL));
            // Only one control frame is queued
            check_value("almost_full", "ctrl_afull stays low", 64'(0), 64'(ctrl_afull));
            ready_mode = 1;
            collect_frame();
            compare_frame("almost_full", 8'h90, 128, 1'b0, 1'b0);
         end
      join
      repeat (2) @(negedge tx_clk);
      check_value("almost_full", "data_afull after drain", 64'(0), 64'(data_afull));
      end_test("almost_full", e0);
   endtask

   initial begin
      rst_n     = 1'b0;
      ctrl_wr   = 1'b0;
      ctrl_data = '0;
      ctrl_tag  = '0;
      ctrl_last = 1'b0;
      data_wr   = 1'b0;
      data_data = '0;
      data_keep = '0;
      data_last = 1'b0;
      repeat (3) @(posedge tx_clk);
      #DRIVE_DLY;
      rst_n = 1'b1;
      test_long_frame();
      test_short_pad();
      test_short_no_pad();
      test_bad_ctrl();
      test_back_pressure();
      test_almost_full();
      $display("Tests run %0d, tests failed %0d, checks failed %0d",
               tests_run, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: hw/eth_tx_path.sv
// ####################
// Top of the Ethernet TX output path
// Control and data FIFOs feed the parser and the MAC emitter
// ####################
`timescale 1ns/1ns
`include "eth_tx_defines.svh"

module eth_tx_path (
   input  logic                       tx_clk,
   input  logic                       rst_n,

   // Control write side
   input  logic                       ctrl_wr,
   input  logic [`ETH_TXC_DATA_W-1:0] ctrl_data,
   input  logic [`ETH_TXC_KEEP_W-1:0] ctrl_tag,
   input  logic                       ctrl_last,
   output logic                       ctrl_afull,

   // Data write side
   input  logic                       data_wr,
   input  logic [`ETH_TXD_DATA_W-1:0] data_data,
   input  logic [`ETH_TXD_KEEP_W-1:0] data_keep,
   input  logic                       data_last,
   output logic                       data_afull,

   // MAC transmit stream
   output logic [`ETH_TXD_DATA_W-1:0] mac_tdata,
   output logic [`ETH_TXD_KEEP_W-1:0] mac_tkeep,
   output logic                       mac_tlast,
   output logic                       mac_tuser,
   output logic                       mac_tvalid,
   input  logic                       mac_tready
);

   import eth_tx_pkg::*;

   eth_tx_stream_if #(.DATA_W(`ETH_TXC_DATA_W), .KEEP_W(`ETH_TXC_KEEP_W)) txc_if ();
   eth_tx_stream_if #(.DATA_W(`ETH_TXD_DATA_W), .KEEP_W(`ETH_TXD_KEEP_W)) txd_if ();

   tx_ctrl_info_t ctrl_info;
   logic          ctrl_valid;
   logic          ctrl_taken;

   // Control words carry their tag in the keep field
   tx_stream_fifo #(
      .DATA_W      (`ETH_TXC_DATA_W),
      .KEEP_W      (`ETH_TXC_KEEP_W),
      .DEPTH       (`ETH_FIFO_DEPTH),
      .AFULL_LEVEL (`ETH_FIFO_AFULL)
   ) u_ctrl_fifo (
      .tx_clk (tx_clk),
      .rst_n  (rst_n),
      .wr     (ctrl_wr),
      .wdata  (ctrl_data),
      .wkeep  (ctrl_tag),
      .wlast  (ctrl_last),
      .afull  (ctrl_afull),
      .rd     (txc_if.source)
   );

   tx_stream_fifo #(
      .DATA_W      (`ETH_TXD_DATA_W),
      .KEEP_W      (`ETH_TXD_KEEP_W),
      .DEPTH       (`ETH_FIFO_DEPTH),
      .AFULL_LEVEL (`ETH_FIFO_AFULL)
   ) u_data_fifo (
      .tx_clk (tx_clk),
      .rst_n  (rst_n),
      .wr     (data_wr),
      .wdata  (data_data),
      .wkeep  (data_keep),
      .wlast  (data_last),
      .afull  (data_afull),
      .rd     (txd_if.source)
   );

   txc_parser u_parser (
      .tx_clk     (tx_clk),
      .rst_n      (rst_n),
      .txc        (txc_if.sink),
      .ctrl_info  (ctrl_info),
      .ctrl_valid (ctrl_valid),
      .ctrl_taken (ctrl_taken)
   );

   tx_frame_emitter u_emitter (
      .tx_clk     (tx_clk),
      .rst_n      (rst_n),
      .txd        (txd_if.sink),
      .ctrl_info  (ctrl_info),
      .ctrl_valid (ctrl_valid),
      .ctrl_taken (ctrl_taken),
      .mac_tdata  (mac_tdata),
      .mac_tkeep  (mac_tkeep),
      .mac_tlast  (mac_tlast),
      .mac_tuser  (mac_tuser),
      .mac_tvalid (mac_tvalid),
      .mac_tready (mac_tready)
   );

endmodule

// File: hw/tx_frame_emitter.sv
// ####################
// Sends one data frame per control summary to the MAC
// Pads short frames with zeros and flags bad control in tuser
// ####################
`timescale 1ns/1ns
`include "eth_tx_defines.svh"

module tx_frame_emitter (
   input  logic                         tx_clk,
   input  logic                         rst_n,
   eth_tx_stream_if.sink                txd,
   input  eth_tx_pkg::tx_ctrl_info_t    ctrl_info,
   input  logic                         ctrl_valid,
   output logic                         ctrl_taken,
   output logic [`ETH_TXD_DATA_W-1:0]   mac_tdata,
   output logic [`ETH_TXD_KEEP_W-1:0]   mac_tkeep,
   output logic                         mac_tlast,
   output logic                         mac_tuser,
   output logic                         mac_tvalid,
   input  logic                         mac_tready
);

   localparam int BEAT_BYTES = `ETH_TXD_KEEP_W;
   localparam int MIN_BYTES  = `ETH_MIN_FRAME_BYTES;
   localparam int PAD_BEATS  = (MIN_BYTES + BEAT_BYTES - 1) / BEAT_BYTES;
   localparam int TAIL_BYTES = MIN_BYTES - (PAD_BEATS - 1) * BEAT_BYTES;
   localparam int CNT_W      = $clog2(PAD_BEATS + 1);
   localparam int LEN_W      = $clog2((PAD_BEATS + 1) * BEAT_BYTES + 1);
   localparam logic [BEAT_BYTES-1:0] TAIL_KEEP = BEAT_BYTES'((1 << TAIL_BYTES) - 1);

   typedef enum logic [1:0] {ST_IDLE, ST_STREAM, ST_PAD} emit_state_t;

   emit_state_t                state;
   emit_state_t                nxt_state;
   logic [CNT_W-1:0]           beat_cnt;
   logic [CNT_W-1:0]           cur_idx;
   logic [LEN_W-1:0]           frame_len;
   logic                       pad_frame;
   logic                       tail_beat;
   logic                       out_free;
   logic                       end_pending;
   logic                       load_in;
   logic                       load_pad;
   logic                       load_beat;
   logic [`ETH_TXD_DATA_W-1:0] nxt_data;
   logic [BEAT_BYTES-1:0]      nxt_keep;
   logic                       nxt_last;

   // Keep is contiguous from byte 0
   function automatic logic [LEN_W-1:0] keep_bytes(input logic [BEAT_BYTES-1:0] keep);
      logic [LEN_W-1:0] n;
      n = '0;
      for (int i = 0; i < BEAT_BYTES; i++) begin
         n = n + LEN_W'(keep[i]);
      end
      return n;
   endfunction

   function automatic logic [`ETH_TXD_DATA_W-1:0] zero_fill(
      input logic [`ETH_TXD_DATA_W-1:0] data,
      input logic [BEAT_BYTES-1:0]      keep
   );
      logic [`ETH_TXD_DATA_W-1:0] d;
      d = data;
      for (int i = 0; i < BEAT_BYTES; i++) begin
         if (!keep[i]) begin
            d[i*8 +: 8] = 8'h00;
         end
      end
      return d;
   endfunction

   assign out_free    = !mac_tvalid || mac_tready;
   // Final beat sits in the output register until the MAC takes it
   assign end_pending = mac_tvalid && mac_tlast;
   assign ctrl_taken  = mac_tvalid && mac_tready && mac_tlast;

   assign load_in = txd.tvalid && out_free && !end_pending &&
                    ((state == ST_IDLE) ? ctrl_valid : (state == ST_STREAM));
   assign load_pad  = out_free && !end_pending && (state == ST_PAD);
   assign load_beat = load_in || load_pad;

   assign txd.tready = load_in;

   always_comb begin
      cur_idx   = (state == ST_IDLE) ? '0 : beat_cnt;
      frame_len = LEN_W'(cur_idx * BEAT_BYTES) + keep_bytes(txd.tkeep);
      pad_frame = !ctrl_info.no_pad && (frame_len < LEN_W'(MIN_BYTES));
      tail_beat = (cur_idx == CNT_W'(PAD_BEATS - 1));

      nxt_data  = txd.tdata;
      nxt_keep  = txd.tkeep;
      nxt_last  = txd.tlast;
      nxt_state = ST_STREAM;
      if (state == ST_PAD) begin
         nxt_data  = '0;
         nxt_keep  = tail_beat ? TAIL_KEEP : '1;
         nxt_last  = tail_beat;
         nxt_state = ST_PAD;
      end else if (txd.tlast && pad_frame) begin
         // Widen the short last beat and continue with zero beats
         nxt_data  = zero_fill(txd.tdata, txd.tkeep);
         nxt_keep  = tail_beat ? TAIL_KEEP : '1;
         nxt_last  = tail_beat;
         nxt_state = tail_beat ? ST_STREAM : ST_PAD;
      end
   end

   always_ff @(posedge tx_clk) begin
      if (!rst_n) begin
         state      <= ST_IDLE;
         beat_cnt   <= '0;
         mac_tvalid <= 1'b0;
      end else begin
         if (ctrl_taken) begin
            state <= ST_IDLE;
         end else if (load_beat) begin
            state <= nxt_state;
         end
         if (load_beat) begin
            mac_tvalid <= 1'b1;
            // Saturates once the frame is past the minimum
            beat_cnt <= (cur_idx == CNT_W'(PAD_BEATS)) ? cur_idx : cur_idx + 1'b1;
         end else if (mac_tready) begin
            mac_tvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge tx_clk) begin
      if (load_beat) begin
         mac_tdata <= nxt_data;
         mac_tkeep <= nxt_keep;
         mac_tlast <= nxt_last;
         mac_tuser <= nxt_last && !ctrl_info.flag_ok;
      end
   end

endmodule

// File: hw/txc_parser.sv
// ####################
// Control frame parser for the TX path
// Checks tags and flag, hands one summary per frame to the emitter
// ####################
`timescale 1ns/1ns
`include "eth_tx_defines.svh"

module txc_parser (
   input  logic                      tx_clk,
   input  logic                      rst_n,
   eth_tx_stream_if.sink             txc,
   output eth_tx_pkg::tx_ctrl_info_t ctrl_info,
   output logic                      ctrl_valid,
   input  logic                      ctrl_taken
);

   import eth_tx_pkg::*;

   localparam int         TAG_W    = `ETH_TXC_KEEP_W;
   localparam logic [2:0] LAST_IDX = 3'd5;

   txc_word_u  word_u;
   logic [2:0] word_cnt;
   logic       acc_ok;
   logic       acc_no_pad;
   logic       frame_end;
   logic       slot_free;
   logic       accept;
   logic       word_ok;
   logic       cur_no_pad;

   assign word_u = txc.tdata;

   // Frame closes on tlast or after the sixth word, whichever is first
   assign frame_end = txc.tlast || (word_cnt == LAST_IDX);
   assign slot_free = !ctrl_valid || ctrl_taken;

   // Only the closing word waits for the summary slot
   assign txc.tready = txc.tvalid && (slot_free || !frame_end);
   assign accept     = txc.tvalid && txc.tready;

   always_comb begin
      word_ok = (txc.tkeep == TAG_W'(word_cnt));
      if (txc.tlast != (word_cnt == LAST_IDX)) begin
         word_ok = 1'b0;
      end
      if ((word_cnt == 3'd0) && (word_u.hdr.flag != `ETH_TXC_FLAG)) begin
         word_ok = 1'b0;
      end
      cur_no_pad = acc_no_pad;
      if (word_cnt == 3'd1) begin
         cur_no_pad = word_u.opt.flags[OPT_NO_PAD];
      end
   end

   always_ff @(posedge tx_clk) begin
      if (!rst_n) begin
         word_cnt   <= '0;
         acc_ok     <= 1'b1;
         acc_no_pad <= 1'b0;
         ctrl_valid <= 1'b0;
      end else if (accept && frame_end) begin
         word_cnt   <= '0;
         acc_ok     <= 1'b1;
         acc_no_pad <= 1'b0;
         ctrl_valid <= 1'b1;
      end else begin
         if (accept) begin
            word_cnt   <= word_cnt + 1'b1;
            acc_ok     <= acc_ok && word_ok;
            acc_no_pad <= cur_no_pad;
         end
         if (ctrl_taken) begin
            ctrl_valid <= 1'b0;
         end
      end
   end

   // Summary held until the emitter takes it
   always_ff @(posedge tx_clk) begin
      if (accept && frame_end) begin
         ctrl_info.flag_ok <= acc_ok && word_ok;
         ctrl_info.no_pad  <= cur_no_pad;
      end
   end

endmodule

// File: hw/tx_stream_fifo.sv
// ####################
// Synchronous FIFO with strobe write and stream read
// Read side is first-word-fall-through
// ####################
`timescale 1ns/1ns

module tx_stream_fifo #(
   parameter int DATA_W      = 64,
   parameter int KEEP_W      = 8,
   parameter int DEPTH       = 16,
   parameter int AFULL_LEVEL = 12
) (
   input  logic              tx_clk,
   input  logic              rst_n,
   input  logic              wr,
   input  logic [DATA_W-1:0] wdata,
   input  logic [KEEP_W-1:0] wkeep,
   input  logic              wlast,
   output logic              afull,
   eth_tx_stream_if.source   rd
);

   localparam int ENTRY_W = DATA_W + KEEP_W + 1;
   localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W   = $clog2(DEPTH + 1);

   logic [ENTRY_W-1:0] mem [DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [CNT_W-1:0]   count;
   logic               push;
   logic               pop;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // Writes into a full FIFO are lost
   assign push = wr && (count != CNT_W'(DEPTH));
   assign pop  = rd.tvalid && rd.tready;

   assign rd.tvalid = (count != '0);
   assign {rd.tlast, rd.tkeep, rd.tdata} = mem[rd_ptr];

   always_ff @(posedge tx_clk) begin
      if (push) begin
         mem[wr_ptr] <= {wlast, wkeep, wdata};
      end
   end

   always_ff @(posedge tx_clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         afull  <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // Lags the count by one cycle
         afull <= (count >= CNT_W'(AFULL_LEVEL));
      end
   end

endmodule

// File: hw/eth_tx_stream_if.sv
// ####################
// Valid/ready stream with data, keep and last
// Source drives the beat, sink drives tready
// ####################
`timescale 1ns/1ns

interface eth_tx_stream_if #(
   parameter int DATA_W = 64,
   parameter int KEEP_W = 8
);

   logic [DATA_W-1:0] tdata;
   logic [KEEP_W-1:0] tkeep;
   logic              tlast;
   logic              tvalid;
   logic              tready;

   // Beat held by the source until tvalid and tready meet
   modport source (
      output tdata, tkeep, tlast, tvalid,
      input  tready
   );

   modport sink (
      input  tdata, tkeep, tlast, tvalid,
      output tready
   );

endinterface

// File: hw/eth_tx_pkg.sv
// ####################
// Types of the TX output path
// Import inside the module body where used
// ####################
`include "eth_tx_defines.svh"

package eth_tx_pkg;

   // Bit index of no_pad within the option bits of word 1
   localparam int OPT_NO_PAD = 0;

   // Word 0 layout
   typedef struct packed {
      logic [3:0]                   flag;
      logic [`ETH_TXC_DATA_W-5:0]   rsvd;
   } txc_hdr_t;

   // Word 1 layout
   typedef struct packed {
      logic [`ETH_TXC_DATA_W-3:0]   rsvd;
      logic [1:0]                   flags;
   } txc_opt_t;

   // One control word seen as header or as options
   typedef union packed {
      txc_hdr_t hdr;
      txc_opt_t opt;
   } txc_word_u;

   // Summary of one control frame for the emitter
   typedef struct packed {
      logic flag_ok;
      logic no_pad;
   } tx_ctrl_info_t;

endpackage

// File: hw/eth_tx_defines.svh
// ####################
// Widths and limits shared by the Ethernet TX output path
// Include wherever a stream width or frame limit is needed
// ####################
`ifndef ETH_TX_DEFINES_SVH
`define ETH_TX_DEFINES_SVH

// Control stream word and tag widths
`define ETH_TXC_DATA_W 32
`define ETH_TXC_KEEP_W 4

// Data stream beat and keep widths
`define ETH_TXD_DATA_W 64
`define ETH_TXD_KEEP_W 8

// FIFO sizing in entries
`define ETH_FIFO_DEPTH 16
`define ETH_FIFO_AFULL 12

// Shortest frame sent to the MAC, FCS excluded
`define ETH_MIN_FRAME_BYTES 60

// Flag nibble expected in control word 0
`define ETH_TXC_FLAG 4'hA

`endif
